// File: cache_pkg.sv
// geometry constants and payload types shared by every i-cache rtl file, referenced by scope
`default_nettype none

package cache_pkg;

    // address split: tag | index | offset
    // byte offset inside one 32-byte line
    localparam int s_offset = 5;
    // set index width
    localparam int s_index = 3;
    // whatever is left of a 32-bit address
    localparam int s_tag = 32 - s_offset - s_index;

    // cache geometry
    localparam int num_sets = 2 ** s_index;
    localparam int num_ways = 2;
    // 32-bit words per line
    localparam int words_per_line = (2 ** s_offset) / 4;

    // instruction word, also used for byte addresses
    typedef logic [31:0] word_t;

    // one full line as moved on the memory side
    typedef logic [(8 * (2 ** s_offset))-1:0] line_t;

    // tag field kept per way
    typedef logic [s_tag-1:0] tag_t;

    // selects one set
    typedef logic [s_index-1:0] index_t;

endpackage : cache_pkg

`default_nettype wire

// File: i_cache_ctrl_if.sv
// bundle between i-cache control and datapath, lookup results one way and load strobes the other
`timescale 1ns/1ps
`default_nettype none

interface i_cache_ctrl_if;

    // lookup results, from the datapath
    // demand line found in one of the ways
    logic hit;
    // way that holds the demand line
    logic hit_way;
    // demand line sits in the prefetch buffer
    logic pf_hit;
    // line after the last miss is already cached or buffered
    logic next_present;
    // victim way of the set being looked up
    logic lru_way;

    // strobes, from control
    // write fill data into the lru way
    logic load_line;
    // fill source, 0 memory, 1 prefetch buffer
    logic line_src;
    // point lru away from the way just used
    logic load_lru;
    // capture memory data into the prefetch buffer
    logic load_pf;
    // invalidate the prefetch buffer
    logic clear_pf;
    // 0 demand line, 1 next line (index and pmem_address)
    logic addr_sel;

    modport datapath (
        output hit, hit_way, pf_hit, next_present, lru_way,
        input  load_line, line_src, load_lru, load_pf, clear_pf, addr_sel
    );

    modport control (
        input  hit, hit_way, pf_hit, next_present, lru_way,
        output load_line, line_src, load_lru, load_pf, clear_pf, addr_sel
    );

endinterface : i_cache_ctrl_if

`default_nettype wire

// File: cache_array.sv
// per-way set storage for one payload type, both ways read at once, written by way enable
`timescale 1ns/1ps
`default_nettype none

module cache_array #(
    parameter type payload_t = cache_pkg::tag_t
) (
    input  logic                            clk,
    input  logic                            reset,
    input  cache_pkg::index_t               index,
    input  logic [cache_pkg::num_ways-1:0]  way_we,
    input  payload_t                        wdata,
    output payload_t                        rdata [cache_pkg::num_ways]
);

    // one entry per set per way
    // contents are only meaningful where the datapath valid bit is set
    payload_t mem [cache_pkg::num_ways][cache_pkg::num_sets];

    // write the enabled way on the edge
    // writes held off while reset is asserted
    always_ff @(posedge clk) begin
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            if (way_we[w] && !reset) begin
                mem[w][index] <= wdata;
            end
        end
    end

    // combinational read of the whole set
    always_comb begin
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            rdata[w] = mem[w][index];
        end
    end

endmodule : cache_array

`default_nettype wire

// File: i_cache_datapath.sv
// i-cache storage, lookup and prefetch buffer, steered by the control fsm through the ctrl bundle
`timescale 1ns/1ps
`default_nettype none

module i_cache_datapath (
    input  logic                clk,
    input  logic                reset,
    input  cache_pkg::word_t    mem_address,
    input  cache_pkg::line_t    pmem_rdata,
    output cache_pkg::word_t    mem_rdata,
    output cache_pkg::word_t    pmem_address,
    i_cache_ctrl_if.datapath    ctrl
);

    // demand address fields
    cache_pkg::tag_t    demand_tag;
    cache_pkg::index_t  demand_index;
    logic [$clog2(cache_pkg::words_per_line)-1:0] word_off;

    // line after the last demand fill, tag and index packed
    logic [cache_pkg::s_tag+cache_pkg::s_index-1:0] next_line_q;
    cache_pkg::tag_t    next_tag;
    cache_pkg::index_t  next_index;

    // set currently looked up and written
    cache_pkg::index_t  rd_index;

    // control state per set
    logic [cache_pkg::num_ways-1:0] valid_q [cache_pkg::num_sets];
    logic [cache_pkg::num_sets-1:0] lru_q;

    // prefetch buffer
    logic               pf_valid_q;
    cache_pkg::tag_t    pf_tag_q;
    cache_pkg::index_t  pf_index_q;
    cache_pkg::line_t   pf_line_q;

    // array ports
    logic [cache_pkg::num_ways-1:0] way_we;
    cache_pkg::tag_t    tag_rdata [cache_pkg::num_ways];
    cache_pkg::line_t   line_rdata [cache_pkg::num_ways];
    cache_pkg::line_t   line_wdata;

    // per-way compare results
    logic [cache_pkg::num_ways-1:0] way_match;
    logic [cache_pkg::num_ways-1:0] next_match;

    // word view of the hit line
    cache_pkg::line_t   hit_line;
    cache_pkg::word_t [cache_pkg::words_per_line-1:0] hit_words;

    // way touched by the current access
    logic               used_way;

    assign demand_tag   = mem_address[31 -: cache_pkg::s_tag];
    assign demand_index = mem_address[cache_pkg::s_offset +: cache_pkg::s_index];
    assign word_off     = mem_address[cache_pkg::s_offset-1:2];

    assign next_tag   = next_line_q[cache_pkg::s_index +: cache_pkg::s_tag];
    assign next_index = next_line_q[cache_pkg::s_index-1:0];

    // next set only while control checks or fetches the prefetch line
    assign rd_index = ctrl.addr_sel ? next_index : demand_index;

    cache_array #(
        .payload_t (cache_pkg::tag_t)
    ) tag_array (
        .clk    (clk),
        .reset  (reset),
        .index  (rd_index),
        .way_we (way_we),
        .wdata  (demand_tag),
        .rdata  (tag_rdata)
    );

    cache_array #(
        .payload_t (cache_pkg::line_t)
    ) line_array (
        .clk    (clk),
        .reset  (reset),
        .index  (rd_index),
        .way_we (way_we),
        .wdata  (line_wdata),
        .rdata  (line_rdata)
    );

    // fill from memory or promote from the buffer
    assign line_wdata = ctrl.line_src ? pf_line_q : pmem_rdata;

    // only the victim way is written
    always_comb begin
        way_we = '0;
        way_we[ctrl.lru_way] = ctrl.load_line;
    end

    // tag compares for the demand line and the next line, same set read
    always_comb begin
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            way_match[w]  = valid_q[rd_index][w] && (tag_rdata[w] == demand_tag);
            next_match[w] = valid_q[rd_index][w] && (tag_rdata[w] == next_tag);
        end
    end

    assign ctrl.hit     = |way_match;
    assign ctrl.hit_way = way_match[1];
    assign ctrl.lru_way = lru_q[rd_index];
    assign ctrl.pf_hit  = pf_valid_q && (pf_tag_q == demand_tag)
                          && (pf_index_q == demand_index);
    // buffer holding the next line counts as present too
    assign ctrl.next_present = (|next_match)
                               || (pf_valid_q && (pf_tag_q == next_tag)
                                   && (pf_index_q == next_index));

    // a fill uses the victim way, a hit the matching one
    assign used_way = ctrl.load_line ? ctrl.lru_way : ctrl.hit_way;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < cache_pkg::num_sets; s++) begin
                valid_q[s] <= '0;
            end
            lru_q      <= '0;
            pf_valid_q <= 1'b0;
        end else begin
            if (ctrl.load_line) begin
                valid_q[rd_index][ctrl.lru_way] <= 1'b1;
            end
            // lru now names the way not just used
            if (ctrl.load_lru) begin
                lru_q[rd_index] <= ~used_way;
            end
            if (ctrl.load_pf) begin
                pf_valid_q <= 1'b1;
            end else if (ctrl.clear_pf) begin
                pf_valid_q <= 1'b0;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        // remember the sequential successor of every filled line
        if (ctrl.load_line) begin
            next_line_q <= mem_address[31:cache_pkg::s_offset] + 1'b1;
        end
        if (ctrl.load_pf) begin
            pf_line_q  <= pmem_rdata;
            pf_tag_q   <= next_tag;
            pf_index_q <= next_index;
        end
    end

    // line-aligned fetch address
    assign pmem_address = ctrl.addr_sel
                          ? {next_line_q, {cache_pkg::s_offset{1'b0}}}
                          : {mem_address[31:cache_pkg::s_offset], {cache_pkg::s_offset{1'b0}}};

    // word select out of the hit way
    assign hit_line  = line_rdata[ctrl.hit_way];
    assign hit_words = hit_line;
    assign mem_rdata = hit_words[word_off];

endmodule : i_cache_datapath

`default_nettype wire

// File: i_cache_control.sv
// i-cache fsm, decides hit, promotion or miss and runs the demand fill and the lookahead fetch
`timescale 1ns/1ps
`default_nettype none

module i_cache_control (
    input  logic            clk,
    input  logic            reset,
    input  logic            mem_read,
    input  logic            pmem_resp,
    output logic            mem_resp,
    output logic            pmem_read,
    i_cache_ctrl_if.control ctrl
);

    typedef enum logic [2:0] {
        st_idle,
        st_fill,
        st_respond,
        st_promote,
        st_prefetch
    } state_t;

    state_t state;
    state_t next_state;

    // set while the current request came through a demand fill
    logic after_miss;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            after_miss <= 1'b0;
        end else begin
            state <= next_state;
            if (state == st_fill) begin
                after_miss <= 1'b1;
            end else if (state == st_respond) begin
                after_miss <= 1'b0;
            end
        end
    end

    always_comb begin
        next_state     = state;
        mem_resp       = 1'b0;
        pmem_read      = 1'b0;
        ctrl.load_line = 1'b0;
        ctrl.line_src  = 1'b0;
        ctrl.load_lru  = 1'b0;
        ctrl.load_pf   = 1'b0;
        ctrl.clear_pf  = 1'b0;
        ctrl.addr_sel  = 1'b0;

        case (state)
            st_idle: begin
                if (mem_read) begin
                    if (ctrl.hit) begin
                        // hit way becomes most recent
                        ctrl.load_lru = 1'b1;
                        next_state    = st_respond;
                    end else if (ctrl.pf_hit) begin
                        next_state = st_promote;
                    end else begin
                        next_state = st_fill;
                    end
                end
            end

            // demand line from memory into the victim way
            st_fill: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    ctrl.load_line = 1'b1;
                    ctrl.load_lru  = 1'b1;
                    next_state     = st_respond;
                end
            end

            // buffer line moves into the victim way and the buffer frees up
            st_promote: begin
                ctrl.load_line = 1'b1;
                ctrl.line_src  = 1'b1;
                ctrl.load_lru  = 1'b1;
                ctrl.clear_pf  = 1'b1;
                next_state     = st_respond;
            end

            // word now resident, one-cycle response
            st_respond: begin
                mem_resp   = 1'b1;
                next_state = after_miss ? st_prefetch : st_idle;
            end

            // lookahead on the line after the miss
            // skipped when that line is already held somewhere
            st_prefetch: begin
                ctrl.addr_sel = 1'b1;
                if (ctrl.next_present) begin
                    next_state = st_idle;
                end else begin
                    pmem_read = 1'b1;
                    if (pmem_resp) begin
                        ctrl.load_pf = 1'b1;
                        next_state   = st_idle;
                    end
                end
            end

            default: begin
                next_state = st_idle;
            end
        endcase
    end

endmodule : i_cache_control

`default_nettype wire

// File: i_cache.sv
// i-cache top level, connects control and datapath to the cpu and line-memory handshakes
`timescale 1ns/1ps
`default_nettype none

module i_cache (
    input  logic                clk,
    input  logic                reset,

    // cpu side, word requests
    input  logic                mem_read,
    input  cache_pkg::word_t    mem_address,
    output logic                mem_resp,
    output cache_pkg::word_t    mem_rdata,

    // memory side, whole lines
    input  cache_pkg::line_t    pmem_rdata,
    input  logic                pmem_resp,
    output cache_pkg::word_t    pmem_address,
    output logic                pmem_read
);

    // lookup results and load strobes
    i_cache_ctrl_if ctrl ();

    // sequencing
    i_cache_control control (
        .clk       (clk),
        .reset     (reset),
        .mem_read  (mem_read),
        .pmem_resp (pmem_resp),
        .mem_resp  (mem_resp),
        .pmem_read (pmem_read),
        .ctrl      (ctrl.control)
    );

    // arrays, buffer and muxes
    i_cache_datapath datapath (
        .clk          (clk),
        .reset        (reset),
        .mem_address  (mem_address),
        .pmem_rdata   (pmem_rdata),
        .mem_rdata    (mem_rdata),
        .pmem_address (pmem_address),
        .ctrl         (ctrl.datapath)
    );

endmodule : i_cache

`default_nettype wire

// File: i_cache_checker.sv
// testbench checker, models the cache rules and compares the dut ports against that model
`timescale 1ns/1ps
`default_nettype none

module i_cache_checker (
    input  logic             clk,
    input  logic             reset,
    input  int               test_num,
    input  cache_pkg::word_t expected_rdata,
    input  logic             mem_read,
    input  cache_pkg::word_t mem_address,
    input  logic             mem_resp,
    input  cache_pkg::word_t mem_rdata,
    input  logic             pmem_read,
    input  cache_pkg::word_t pmem_address,
    input  logic             pmem_resp,
    output int               error_count,
    output int               request_count,
    output logic             quiet
);

    // model contents, lines held as byte address >> 5
    logic [31:0] way_line [cache_pkg::num_sets][cache_pkg::num_ways];
    logic        way_valid [cache_pkg::num_sets][cache_pkg::num_ways];
    logic        victim [cache_pkg::num_sets];
    logic        buf_valid;
    logic [31:0] buf_line;
    // line fetches still owed by the cache, oldest first
    cache_pkg::word_t fetch_q [$];
    // 0 idle, 1 read outstanding, 2 lookahead window after a miss
    int   phase = 0;
    int   latency;
    // cycles from sample to mem_resp
    // a miss learns it when its line arrives
    int   expected_latency;
    // request went out to memory
    logic was_miss;
    logic prefetch_due;
    int   current_test = 0;
    int   test_reads = 0;
    int   test_errors = 0;

    initial begin
        error_count = 0;
        request_count = 0;
        quiet = 1'b0;
    end

    // way holding the line, -1 when absent
    function automatic int find_way(input logic [31:0] line);
        int found;
        found = -1;
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            if (way_valid[line % cache_pkg::num_sets][w]
                && way_line[line % cache_pkg::num_sets][w] == line) begin
                found = w;
            end
        end
        return found;
    endfunction

    // victim way takes the line, lru moves to the other way
    task automatic place_line(input logic [31:0] line);
        int set;
        set = line % cache_pkg::num_sets;
        way_line[set][victim[set]] = line;
        way_valid[set][victim[set]] = 1'b1;
        victim[set] = ~victim[set];
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("ERROR at %0t: %s", $time, what);
        error_count++;
        test_errors++;
    endtask

    // classify the read the dut samples now and update the model
    task automatic start_request();
        logic [31:0] line;
        int way;
        line = mem_address >> cache_pkg::s_offset;
        way = find_way(line);
        latency = 0;
        prefetch_due = 1'b0;
        was_miss = 1'b0;
        if (way >= 0) begin
            expected_latency = 1;
            victim[line % cache_pkg::num_sets] = (way == 0);
        end else if (buf_valid && buf_line == line) begin
            // promotion then response
            expected_latency = 2;
            place_line(line);
            buf_valid = 1'b0;
        end else begin
            expected_latency = 0;
            was_miss = 1'b1;
            place_line(line);
            fetch_q.push_back(line << cache_pkg::s_offset);
            // lookahead only for a line held nowhere yet
            prefetch_due = (find_way(line + 1) < 0) && !(buf_valid && buf_line == line + 1);
            if (prefetch_due) begin
                fetch_q.push_back((line + 1) << cache_pkg::s_offset);
                buf_valid = 1'b1;
                buf_line = line + 1;
            end
        end
        phase = 1;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < cache_pkg::num_sets; s++) begin
                victim[s] = 1'b0;
                way_valid[s] = '{default: 1'b0};
            end
            buf_valid = 1'b0;
            fetch_q.delete();
            phase = 0;
        end else begin
            // a new test number closes the previous test
            if (test_num != current_test) begin
                if (current_test != 0) begin
                    $display("test %0d done: %0d reads, %0d errors",
                             current_test, test_reads, test_errors);
                end
                current_test = test_num;
                test_reads = 0;
                test_errors = 0;
            end
            if (pmem_read && fetch_q.size() == 0) begin
                report_problem("pmem_read high although no line fetch was due");
            end
            if (pmem_read && pmem_resp && fetch_q.size() > 0) begin
                compare("pmem_address", fetch_q.pop_front(), pmem_address);
            end
            if (mem_resp && phase != 1) begin
                report_problem("mem_resp went high with no read outstanding");
            end
            case (phase)
                0: begin
                    if (mem_read) begin
                        start_request();
                    end
                end
                1: begin
                    latency++;
                    // a miss answers one cycle after its line arrives
                    if (was_miss && pmem_read && pmem_resp) begin
                        expected_latency = latency + 1;
                    end
                    if (mem_resp) begin
                        compare("mem_rdata", expected_rdata, mem_rdata);
                        compare("mem_resp latency", expected_latency, latency);
                        request_count++;
                        test_reads++;
                        phase = was_miss ? 2 : 0;
                    end
                end
                default: begin
                    // one cycle when skipped, else until the line arrives
                    if (!prefetch_due || (pmem_read && pmem_resp)) begin
                        phase = 0;
                    end
                end
            endcase
        end
        quiet = (phase == 0) && (fetch_q.size() == 0);
    end

endmodule : i_cache_checker

`default_nettype wire

// File: tb_i_cache.sv
// testbench top for the i-cache, runs a table of word reads against a random-latency line memory
`timescale 1ns/1ps
`default_nettype none

module tb_i_cache;

    // memory answers after 1 to mem_lat_span cycles
    localparam int mem_lat_span = 6;
    localparam int random_reads = 24;
    // slowest read: fill, response, prefetch fill, idle
    localparam int worst_req_cycles = 16;

    logic             clk;
    logic             reset;
    logic             mem_read;
    cache_pkg::word_t mem_address;
    logic             mem_resp;
    cache_pkg::word_t mem_rdata;
    cache_pkg::line_t pmem_rdata;
    logic             pmem_resp;
    cache_pkg::word_t pmem_address;
    logic             pmem_read;

    // stimulus table: test number, read address, expected word
    int               table_test [$];
    cache_pkg::word_t table_addr [$];
    cache_pkg::word_t table_data [$];

    int               test_num;
    cache_pkg::word_t expected_rdata;
    int               error_count;
    int               request_count;
    logic             quiet;

    logic [31:0] rng_state = 32'hce3a;
    logic        mem_busy;
    int          mem_wait;
    int          cycle_count = 0;
    int          timeout_cycles = 0;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // every memory word is its byte address xor 5a5a0000
    function automatic cache_pkg::word_t word_pattern(input cache_pkg::word_t addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    function automatic cache_pkg::line_t line_pattern(input cache_pkg::word_t base);
        cache_pkg::line_t data;
        for (int w = 0; w < cache_pkg::words_per_line; w++) begin
            data[32*w +: 32] = word_pattern(base + 4 * w);
        end
        return data;
    endfunction

    task automatic add_read(input int test, input cache_pkg::word_t addr);
        table_test.push_back(test);
        table_addr.push_back(addr);
        table_data.push_back(word_pattern(addr));
    endtask

    task automatic build_table();
        // first read after reset
        add_read(1, 32'h0000_0100);
        // all word offsets of one line, last word first
        for (int w = 0; w < cache_pkg::words_per_line; w++) begin
            add_read(2, 32'h0000_021c - 4 * w);
        end
        // resident line again
        add_read(3, 32'h0000_0104);
        add_read(3, 32'h0000_0104);
        add_read(3, 32'h0000_0118);
        // miss on L, then L+1 from the buffer, then L+2 and L+3
        add_read(4, 32'h0000_0400);
        add_read(4, 32'h0000_0424);
        add_read(4, 32'h0000_0448);
        add_read(4, 32'h0000_046c);
        // set 5: a, b, a, c drops b, then a hits and b misses
        add_read(5, 32'h0000_10a0);
        add_read(5, 32'h0000_20a4);
        add_read(5, 32'h0000_10a8);
        add_read(5, 32'h0000_30ac);
        add_read(5, 32'h0000_10b0);
        add_read(5, 32'h0000_20b4);
        // random words over 32 lines, so sets collide
        repeat (random_reads) begin
            add_read(6, next_random() & 32'h0000_03fc);
        end
    endtask

    // present one read on the falling edge and hold it until mem_resp
    task automatic apply_read(input int i);
        @(negedge clk);
        mem_read = 1'b1;
        mem_address = table_addr[i];
        expected_rdata = table_data[i];
        test_num = table_test[i];
        @(posedge clk);
        while (!mem_resp) begin
            @(posedge clk);
        end
    endtask

    i_cache UUT (
        .clk          (clk),
        .reset        (reset),
        .mem_read     (mem_read),
        .mem_address  (mem_address),
        .mem_resp     (mem_resp),
        .mem_rdata    (mem_rdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp),
        .pmem_address (pmem_address),
        .pmem_read    (pmem_read)
    );

    i_cache_checker scoreboard (
        .clk            (clk),
        .reset          (reset),
        .test_num       (test_num),
        .expected_rdata (expected_rdata),
        .mem_read       (mem_read),
        .mem_address    (mem_address),
        .mem_resp       (mem_resp),
        .mem_rdata      (mem_rdata),
        .pmem_read      (pmem_read),
        .pmem_address   (pmem_address),
        .pmem_resp      (pmem_resp),
        .error_count    (error_count),
        .request_count  (request_count),
        .quiet          (quiet)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // line memory, one outstanding read, one-cycle pmem_resp
    always @(negedge clk) begin
        if (reset || pmem_resp) begin
            pmem_resp = 1'b0;
            mem_busy = 1'b0;
        end else if (mem_busy) begin
            if (mem_wait == 0) begin
                pmem_resp = 1'b1;
                pmem_rdata = line_pattern(pmem_address);
            end else begin
                mem_wait--;
            end
        end else if (pmem_read) begin
            mem_busy = 1'b1;
            mem_wait = next_random() % mem_lat_span;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (timeout_cycles > 0 && cycle_count > timeout_cycles) begin
            $display("run timed out after %0d cycles before the table was done", cycle_count);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        mem_read = 1'b0;
        mem_address = '0;
        pmem_resp = 1'b0;
        pmem_rdata = '0;
        mem_busy = 1'b0;
        mem_wait = 0;
        test_num = 0;
        expected_rdata = '0;
        build_table();
        timeout_cycles = 20 * table_addr.size() * worst_req_cycles;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // idle gap, outputs must stay low here
        repeat (3) @(negedge clk);
        for (int i = 0; i < table_addr.size(); i++) begin
            apply_read(i);
        end
        @(negedge clk);
        mem_read = 1'b0;
        // trailing prefetch has to drain
        while (!quiet) begin
            @(negedge clk);
        end
        test_num = 0;
        @(negedge clk);
        $display("%0d of %0d reads answered, %0d errors",
                 request_count, table_addr.size(), error_count);
        if (error_count == 0 && request_count == table_addr.size()) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : tb_i_cache

`default_nettype wire

// File: filelist.f
cache_pkg.sv
i_cache_ctrl_if.sv
cache_array.sv
i_cache_datapath.sv
i_cache_control.sv
i_cache.sv
i_cache_checker.sv
tb_i_cache.sv

// File: Bender.yml
package:
  name: i_cache

sources:
  - cache_pkg.sv
  - i_cache_ctrl_if.sv
  - cache_array.sv
  - i_cache_datapath.sv
  - i_cache_control.sv
  - i_cache.sv
  - target: test
    files:
      - i_cache_checker.sv
      - tb_i_cache.sv
